// ==== source/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_ADDR_W 14
`define CSR_DATA_W 32
`define CNT_W 64
`define HW_INT_W 8
`define SAVE_NUM 4

// direct address mode out of reset
`define CRMD_RST 32'h0000_0008

`define CRMD_PLV 1:0
`define CRMD_IE 2
`define CRMD_DA 3
`define CRMD_PG 4
`define CRMD_DATF 6:5
`define CRMD_DATM 8:7

`define PRMD_PPLV 1:0
`define PRMD_PIE 2

`define ESTAT_IS_SW 1:0
`define ESTAT_IS_HW 9:2
`define ESTAT_IS_TI 11
`define ESTAT_ECODE 21:16
`define ESTAT_ESUBCODE 30:22

`define EENTRY_VA 31:6

`define TCFG_EN 0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL 31:2

`define TICLR_CLR 0

`endif

// ==== source/csr_pkg.sv ====
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

  typedef enum logic [`CSR_ADDR_W-1:0] {
    CRMD   = 14'h0,
    PRMD   = 14'h1,
    ESTAT  = 14'h5,
    ERA    = 14'h6,
    EENTRY = 14'hc,
    SAVE0  = 14'h30,
    SAVE1  = 14'h31,
    SAVE2  = 14'h32,
    SAVE3  = 14'h33,
    TID    = 14'h40,
    TCFG   = 14'h41,
    TVAL   = 14'h42,
    TICLR  = 14'h44
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR       = 2'd0, // plain csr read
    CNT_ID    = 2'd1,
    CNT_VLOW  = 2'd2,
    CNT_VHIGH = 2'd3
  } rdcnt_e;

  typedef enum logic [5:0] {
    INT = 6'h0,
    ADE = 6'h8,
    ALE = 6'h9,
    SYS = 6'hb,
    BRK = 6'hc,
    INE = 6'hd
  } ecode_e;

  typedef logic [`CSR_DATA_W-1:0] csr_word_t;

  typedef struct packed {
    logic      we;   // committed this cycle
    csr_addr_e addr;
    csr_word_t mask;
    csr_word_t data;
  } csr_wr_t;

  typedef struct packed {
    logic       valid;
    ecode_e     ecode;
    logic [8:0] esubcode;
    csr_word_t  pc;
  } excp_t;

  typedef struct packed {
    csr_word_t crmd;
    csr_word_t prmd;
    csr_word_t estat;
    csr_word_t era;
    csr_word_t eentry;
  } excp_view_t;

  typedef struct packed {
    csr_word_t             tid;
    csr_word_t             tcfg;
    csr_word_t             tval;
    logic [`CNT_W-1:0]     cnt;
  } timer_view_t;

  typedef struct packed {
    logic [1:0] plv;
    logic       ie;
    logic       da;
    logic       pg;
    csr_word_t  eentry;
    csr_word_t  era;
    logic       int_req;
  } csr_status_t;

  // masked update rule shared by every writable register
  function automatic csr_word_t masked_wr(csr_word_t old, csr_word_t mask, csr_word_t data);
    return (old & ~mask) | (data & mask);
  endfunction

endpackage

`default_nettype wire

// ==== source/csr_excp_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_excp_regs (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire csr_pkg::csr_wr_t    csr_wr_i,
  input  wire csr_pkg::excp_t      excp_i,
  input  wire                      ertn_i,
  input  wire [`HW_INT_W-1:0]      hw_int_i,
  input  wire                      timer_int_i,
  output csr_pkg::excp_view_t      view_o,
  output csr_pkg::csr_status_t     status_o
);

  csr_pkg::csr_word_t crmd_q, prmd_q, era_q, eentry_q;
  csr_pkg::csr_word_t crmd_wd, prmd_wd, estat_wd, era_wd, eentry_wd;
  csr_pkg::csr_word_t estat;
  logic [1:0]           is_sw_q;
  logic [`HW_INT_W-1:0] is_hw_q;
  csr_pkg::ecode_e      ecode_q;
  logic [8:0]           esubcode_q;
  logic crmd_we, prmd_we, estat_we, era_we, eentry_we;

  assign crmd_we   = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::CRMD);
  assign prmd_we   = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::PRMD);
  assign estat_we  = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::ESTAT);
  assign era_we    = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::ERA);
  assign eentry_we = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::EENTRY);

  assign crmd_wd   = csr_pkg::masked_wr(crmd_q, csr_wr_i.mask, csr_wr_i.data);
  assign prmd_wd   = csr_pkg::masked_wr(prmd_q, csr_wr_i.mask, csr_wr_i.data);
  assign estat_wd  = csr_pkg::masked_wr(estat, csr_wr_i.mask, csr_wr_i.data);
  assign era_wd    = csr_pkg::masked_wr(era_q, csr_wr_i.mask, csr_wr_i.data);
  assign eentry_wd = csr_pkg::masked_wr(eentry_q, csr_wr_i.mask, csr_wr_i.data);

  // write > exception > ertn
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= `CRMD_RST;
    end else if (crmd_we) begin
      crmd_q[`CRMD_PLV]  <= crmd_wd[`CRMD_PLV];
      crmd_q[`CRMD_IE]   <= crmd_wd[`CRMD_IE];
      crmd_q[`CRMD_DA]   <= crmd_wd[`CRMD_DA];
      crmd_q[`CRMD_PG]   <= crmd_wd[`CRMD_PG];
      crmd_q[`CRMD_DATF] <= crmd_wd[`CRMD_DATF];
      crmd_q[`CRMD_DATM] <= crmd_wd[`CRMD_DATM];
    end else if (excp_i.valid) begin
      crmd_q[`CRMD_PLV] <= 2'b00; // kernel, irq off
      crmd_q[`CRMD_IE]  <= 1'b0;
    end else if (ertn_i) begin
      crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
      crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prmd_q <= '0;
    end else if (prmd_we) begin
      prmd_q[`PRMD_PPLV] <= prmd_wd[`PRMD_PPLV];
      prmd_q[`PRMD_PIE]  <= prmd_wd[`PRMD_PIE];
    end else if (excp_i.valid) begin
      prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
      prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_sw_q    <= '0;
      is_hw_q    <= '0;
      ecode_q    <= csr_pkg::INT;
      esubcode_q <= '0;
    end else begin
      is_hw_q <= hw_int_i; // sampled every cycle
      if (estat_we) begin
        is_sw_q <= estat_wd[`ESTAT_IS_SW];
      end
      if (excp_i.valid) begin
        ecode_q    <= excp_i.ecode;
        esubcode_q <= excp_i.esubcode;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q    <= '0;
      eentry_q <= '0;
    end else begin
      if (era_we) begin
        era_q <= era_wd;
      end else if (excp_i.valid) begin
        era_q <= excp_i.pc;
      end
      if (eentry_we) begin
        eentry_q[`EENTRY_VA] <= eentry_wd[`EENTRY_VA];
      end
    end
  end

  always_comb begin
    estat                   = '0;
    estat[`ESTAT_IS_SW]     = is_sw_q;
    estat[`ESTAT_IS_HW]     = is_hw_q;
    estat[`ESTAT_IS_TI]     = timer_int_i; // flag lives in the timer
    estat[`ESTAT_ECODE]     = ecode_q;
    estat[`ESTAT_ESUBCODE]  = esubcode_q;
  end

  assign view_o.crmd   = crmd_q;
  assign view_o.prmd   = prmd_q;
  assign view_o.estat  = estat;
  assign view_o.era    = era_q;
  assign view_o.eentry = eentry_q;

  assign status_o.plv     = crmd_q[`CRMD_PLV];
  assign status_o.ie      = crmd_q[`CRMD_IE];
  assign status_o.da      = crmd_q[`CRMD_DA];
  assign status_o.pg      = crmd_q[`CRMD_PG];
  assign status_o.eentry  = eentry_q;
  assign status_o.era     = era_q;
  assign status_o.int_req = crmd_q[`CRMD_IE] && (|{timer_int_i, is_hw_q, is_sw_q});

endmodule

`default_nettype wire

// ==== source/csr_timer.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_timer (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire csr_pkg::csr_wr_t  csr_wr_i,
  output logic                   timer_int_o,
  output csr_pkg::timer_view_t   view_o
);

  csr_pkg::csr_word_t tid_q, tcfg_q, tval_q;
  csr_pkg::csr_word_t tid_wd, tcfg_wd, ticlr_wd;
  logic              en_q;
  logic              ti_q;
  logic [`CNT_W-1:0] cnt_q;
  logic tid_we, tcfg_we, ticlr_we;
  logic expire;

  assign tid_we   = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::TID);
  assign tcfg_we  = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::TCFG);
  assign ticlr_we = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::TICLR);

  assign tid_wd   = csr_pkg::masked_wr(tid_q, csr_wr_i.mask, csr_wr_i.data);
  assign tcfg_wd  = csr_pkg::masked_wr(tcfg_q, csr_wr_i.mask, csr_wr_i.data);
  assign ticlr_wd = csr_pkg::masked_wr('0, csr_wr_i.mask, csr_wr_i.data); // reads as zero

  assign expire = en_q && (tval_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_q <= '0;
    end else if (tid_we) begin
      tid_q <= tid_wd;
    end
  end

  // tcfg write restarts the countdown
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q <= '0;
      tval_q <= '0;
      en_q   <= 1'b0;
    end else if (tcfg_we) begin
      tcfg_q <= tcfg_wd;
      tval_q <= {tcfg_wd[`TCFG_INITVAL], 2'b00};
      en_q   <= tcfg_wd[`TCFG_EN];
    end else if (expire) begin
      if (tcfg_q[`TCFG_PERIODIC]) begin
        tval_q <= {tcfg_q[`TCFG_INITVAL], 2'b00};
      end else begin
        en_q <= 1'b0; // one-shot done
      end
    end else if (en_q) begin
      tval_q <= tval_q - 1'b1;
    end
  end

  // clear wins over a set in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ti_q <= 1'b0;
    end else if (ticlr_we && ticlr_wd[`TICLR_CLR]) begin
      ti_q <= 1'b0;
    end else if (expire) begin
      ti_q <= 1'b1;
    end
  end

  // stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign timer_int_o = ti_q;
  assign view_o.tid  = tid_q;
  assign view_o.tcfg = tcfg_q;
  assign view_o.tval = tval_q;
  assign view_o.cnt  = cnt_q;

endmodule

`default_nettype wire

// ==== source/csr_save_bank.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_save_bank (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire csr_pkg::csr_wr_t                csr_wr_i,
  output csr_pkg::csr_word_t [`SAVE_NUM-1:0]   save_o
);

  for (genvar i = 0; i < `SAVE_NUM; i++) begin : g_save
    logic               we;
    csr_pkg::csr_word_t save_q;

    // SAVE0..SAVE3 are consecutive
    assign we = csr_wr_i.we && (csr_wr_i.addr == csr_pkg::SAVE0 + `CSR_ADDR_W'(i));

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        save_q <= '0;
      end else if (we) begin
        save_q <= csr_pkg::masked_wr(save_q, csr_wr_i.mask, csr_wr_i.data);
      end
    end

    assign save_o[i] = save_q;
  end

endmodule

`default_nettype wire

// ==== source/csr_read_mux.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_read_mux (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire [`CSR_ADDR_W-1:0]                   rd_addr_i,
  input  wire csr_pkg::rdcnt_e                    rdcnt_i,
  input  wire                                     stall_i,
  input  wire csr_pkg::excp_view_t                excp_view_i,
  input  wire csr_pkg::timer_view_t               timer_view_i,
  input  wire csr_pkg::csr_word_t [`SAVE_NUM-1:0] save_i,
  output csr_pkg::csr_word_t                      rd_data_o
);

  csr_pkg::csr_word_t rd_sel;

  always_comb begin
    rd_sel = '0;
    case (rdcnt_i)
      csr_pkg::CNT_ID:    rd_sel = timer_view_i.tid;
      csr_pkg::CNT_VLOW:  rd_sel = timer_view_i.cnt[`CSR_DATA_W-1:0];
      csr_pkg::CNT_VHIGH: rd_sel = timer_view_i.cnt[`CNT_W-1:`CSR_DATA_W];
      default: begin
        case (rd_addr_i)
          csr_pkg::CRMD:   rd_sel = excp_view_i.crmd;
          csr_pkg::PRMD:   rd_sel = excp_view_i.prmd;
          csr_pkg::ESTAT:  rd_sel = excp_view_i.estat;
          csr_pkg::ERA:    rd_sel = excp_view_i.era;
          csr_pkg::EENTRY: rd_sel = excp_view_i.eentry;
          csr_pkg::SAVE0:  rd_sel = save_i[0];
          csr_pkg::SAVE1:  rd_sel = save_i[1];
          csr_pkg::SAVE2:  rd_sel = save_i[2];
          csr_pkg::SAVE3:  rd_sel = save_i[3];
          csr_pkg::TID:    rd_sel = timer_view_i.tid;
          csr_pkg::TCFG:   rd_sel = timer_view_i.tcfg;
          csr_pkg::TVAL:   rd_sel = timer_view_i.tval;
          csr_pkg::TICLR:  rd_sel = '0; // write-only clear
          default:         rd_sel = '0;
        endcase
      end
    endcase
  end

  // held while the pipeline stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data_o <= '0;
    end else if (!stall_i) begin
      rd_data_o <= rd_sel;
    end
  end

endmodule

`default_nettype wire

// ==== source/csr_file.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_file (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire csr_pkg::csr_wr_t    csr_wr_i,
  input  wire csr_pkg::excp_t      excp_i,
  input  wire                      ertn_i,
  input  wire [`HW_INT_W-1:0]      hw_int_i,
  input  wire [`CSR_ADDR_W-1:0]    rd_addr_i,
  input  wire csr_pkg::rdcnt_e     rdcnt_i,
  input  wire                      stall_i,
  output csr_pkg::csr_word_t       rd_data_o,
  output csr_pkg::csr_status_t     csr_o
);

  logic                                timer_int;
  csr_pkg::excp_view_t                 excp_view;
  csr_pkg::timer_view_t                timer_view;
  csr_pkg::csr_word_t [`SAVE_NUM-1:0]  save_words;

  csr_excp_regs excp_regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_wr_i    (csr_wr_i),
    .excp_i      (excp_i),
    .ertn_i      (ertn_i),
    .hw_int_i    (hw_int_i),
    .timer_int_i (timer_int),
    .view_o      (excp_view),
    .status_o    (csr_o)
  );

  csr_timer timer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_wr_i    (csr_wr_i),
    .timer_int_o (timer_int),
    .view_o      (timer_view)
  );

  csr_save_bank save_bank_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .csr_wr_i (csr_wr_i),
    .save_o   (save_words)
  );

  csr_read_mux read_mux_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_addr_i    (rd_addr_i),
    .rdcnt_i      (rdcnt_i),
    .stall_i      (stall_i),
    .excp_view_i  (excp_view),
    .timer_view_i (timer_view),
    .save_i       (save_words),
    .rd_data_o    (rd_data_o)
  );

endmodule

`default_nettype wire

// ==== testbench/csr_file_chk.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_file_chk (
  input wire                       clk,
  input wire                       rst_n,
  input wire csr_pkg::csr_wr_t     wr_i,
  input wire csr_pkg::excp_t       excp_i,
  input wire [`HW_INT_W-1:0]       hw_int_i,
  input wire                       stall_i,
  input wire csr_pkg::csr_word_t   rd_data_i,
  input wire csr_pkg::csr_status_t status_i
);

  int unsigned fail_cnt = 0;
  logic        crmd_wr;

  assign crmd_wr = wr_i.we && (wr_i.addr == csr_pkg::CRMD);

  // read port frozen under back-pressure
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> $stable(rd_data_i))
    else begin
      fail_cnt++;
      $error("rd_data_o changed while stall_i was high");
    end

  // sampled hw line pending so int_req follows IE
  a_int_req_ie: assert property (@(posedge clk) disable iff (!rst_n)
    (|$past(hw_int_i)) |-> (status_i.int_req == status_i.ie))
    else begin
      fail_cnt++;
      $error("int_req does not follow CRMD.IE with a hardware interrupt pending");
    end

  // exception entry drops to kernel with irq off
  a_excp_entry: assert property (@(posedge clk) disable iff (!rst_n)
    (excp_i.valid && !crmd_wr) |=> (status_i.plv == 2'b00 && !status_i.ie))
    else begin
      fail_cnt++;
      $error("PLV or IE not cleared after exception entry");
    end

endmodule

`default_nettype wire

// ==== testbench/csr_file_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_file_tb;

  localparam int RST_CYC = 5;
  localparam int N_RESET = 16;
  localparam int N_WRITE = 400;
  localparam int N_EXCP  = 300;
  localparam int N_TIMER = 600;
  localparam int N_CNT   = 200;
  localparam int N_STALL = 400;
  localparam int LIMIT   = RST_CYC + N_RESET + N_WRITE + N_EXCP + N_TIMER + N_CNT
                           + N_STALL + 50;

  logic                   clk = 1'b0;
  logic                   rst_n;
  csr_pkg::csr_wr_t       csr_wr;
  csr_pkg::excp_t         excp;
  logic                   ertn;
  logic [`HW_INT_W-1:0]   hw_int;
  logic [`CSR_ADDR_W-1:0] rd_addr;
  csr_pkg::rdcnt_e        rdcnt;
  logic                   stall;
  csr_pkg::csr_word_t     rd_data;
  csr_pkg::csr_status_t   csr_st;

  // reference model state
  csr_pkg::csr_word_t   m_crmd, m_prmd, m_era, m_eentry, m_tid, m_tcfg, m_tval, m_rd;
  csr_pkg::csr_word_t   m_save [`SAVE_NUM];
  logic [1:0]           m_is_sw;
  logic [`HW_INT_W-1:0] m_is_hw;
  logic [5:0]           m_ecode;
  logic [8:0]           m_esub;
  logic                 m_en, m_ti;
  logic [`CNT_W-1:0]    m_cnt;

  logic [31:0] lfsr = 32'h35a5c75e;
  int errors = 0;
  int checks = 0;
  int tests_pass = 0;
  int tests_fail = 0;
  int cycles = 0;

  logic [`CSR_ADDR_W-1:0] kept_addr [13] = '{14'h000, 14'h001, 14'h005, 14'h006, 14'h00c,
    14'h030, 14'h031, 14'h032, 14'h033, 14'h040, 14'h041, 14'h042, 14'h044};
  logic [`CSR_ADDR_W-1:0] excp_rd [4] = '{14'h000, 14'h001, 14'h005, 14'h006};
  logic [`CSR_ADDR_W-1:0] tmr_rd [4] = '{14'h042, 14'h041, 14'h005, 14'h044};
  csr_pkg::ecode_e ecodes [6] = '{csr_pkg::INT, csr_pkg::ADE, csr_pkg::ALE, csr_pkg::SYS,
    csr_pkg::BRK, csr_pkg::INE};

  csr_file dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_wr_i  (csr_wr),
    .excp_i    (excp),
    .ertn_i    (ertn),
    .hw_int_i  (hw_int),
    .rd_addr_i (rd_addr),
    .rdcnt_i   (rdcnt),
    .stall_i   (stall),
    .rd_data_o (rd_data),
    .csr_o     (csr_st)
  );

  bind csr_file csr_file_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (csr_wr_i),
    .excp_i    (excp_i),
    .hw_int_i  (hw_int_i),
    .stall_i   (stall_i),
    .rd_data_i (rd_data_o),
    .status_i  (csr_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  // mostly kept addresses, now and then an unmapped one
  function automatic logic [`CSR_ADDR_W-1:0] pick_addr();
    logic [3:0] ai;
    ai = 4'(rand_bits(4));
    if (ai < 4'd13) begin
      return kept_addr[ai];
    end
    return {10'h200, ai};
  endfunction

  function automatic csr_pkg::csr_word_t masked_merge(csr_pkg::csr_word_t old,
                                                      csr_pkg::csr_word_t wbits);
    return ((old & ~csr_wr.mask) | (csr_wr.data & csr_wr.mask)) & wbits;
  endfunction

  function automatic csr_pkg::csr_word_t model_estat();
    return {1'b0, m_esub, m_ecode, 4'b0, m_ti, 1'b0, m_is_hw, m_is_sw};
  endfunction

  function automatic csr_pkg::csr_word_t model_read(logic [`CSR_ADDR_W-1:0] a,
                                                    csr_pkg::rdcnt_e rc);
    case (rc)
      csr_pkg::CNT_ID:    return m_tid;
      csr_pkg::CNT_VLOW:  return m_cnt[31:0];
      csr_pkg::CNT_VHIGH: return m_cnt[63:32];
      default: ;
    endcase
    case (a)
      14'h000: return m_crmd;
      14'h001: return m_prmd;
      14'h005: return model_estat();
      14'h006: return m_era;
      14'h00c: return m_eentry;
      14'h030, 14'h031, 14'h032, 14'h033: return m_save[a[1:0]];
      14'h040: return m_tid;
      14'h041: return m_tcfg;
      14'h042: return m_tval;
      default: return '0; // ticlr too
    endcase
  endfunction

  function automatic csr_pkg::csr_status_t model_status();
    csr_pkg::csr_status_t s;
    s.plv     = m_crmd[1:0];
    s.ie      = m_crmd[2];
    s.da      = m_crmd[3];
    s.pg      = m_crmd[4];
    s.eentry  = m_eentry;
    s.era     = m_era;
    s.int_req = m_crmd[2] & (m_ti | (|m_is_hw) | (|m_is_sw));
    return s;
  endfunction

  task automatic model_reset();
    m_crmd   = 32'h0000_0008;
    m_prmd   = '0;
    m_era    = '0;
    m_eentry = '0;
    m_tid    = '0;
    m_tcfg   = '0;
    m_tval   = '0;
    m_rd     = '0;
    m_is_sw  = '0;
    m_is_hw  = '0;
    m_ecode  = '0;
    m_esub   = '0;
    m_en     = 1'b0;
    m_ti     = 1'b0;
    m_cnt    = '0;
    foreach (m_save[i]) begin
      m_save[i] = '0;
    end
  endtask

  // one clock edge, using the inputs the DUT just sampled
  task automatic model_step();
    logic                   we;
    logic [`CSR_ADDR_W-1:0] wa;
    logic                   expire;
    csr_pkg::csr_word_t     old_crmd;
    we       = csr_wr.we;
    wa       = csr_wr.addr;
    old_crmd = m_crmd;
    expire   = m_en && (m_tval == '0);
    if (!stall) begin
      m_rd = model_read(rd_addr, rdcnt);
    end
    if (we && wa == 14'h000) begin
      m_crmd = masked_merge(m_crmd, 32'h0000_01ff);
    end else if (excp.valid) begin
      m_crmd[2:0] = 3'b000;
    end else if (ertn) begin
      m_crmd[2:0] = m_prmd[2:0];
    end
    if (we && wa == 14'h001) begin
      m_prmd = masked_merge(m_prmd, 32'h0000_0007);
    end else if (excp.valid) begin
      m_prmd[2:0] = old_crmd[2:0];
    end
    if (we && wa == 14'h005) begin
      m_is_sw = (m_is_sw & ~csr_wr.mask[1:0]) | (csr_wr.data[1:0] & csr_wr.mask[1:0]);
    end
    m_is_hw = hw_int;
    if (excp.valid) begin
      m_ecode = excp.ecode;
      m_esub  = excp.esubcode;
    end
    if (we && wa == 14'h006) begin
      m_era = masked_merge(m_era, '1);
    end else if (excp.valid) begin
      m_era = excp.pc;
    end
    if (we && wa == 14'h00c) begin
      m_eentry = masked_merge(m_eentry, 32'hffff_ffc0);
    end
    if (we && wa[13:2] == 12'h00c) begin
      m_save[wa[1:0]] = masked_merge(m_save[wa[1:0]], '1);
    end
    if (we && wa == 14'h040) begin
      m_tid = masked_merge(m_tid, '1);
    end
    if (we && wa == 14'h044 && csr_wr.mask[0] && csr_wr.data[0]) begin
      m_ti = 1'b0;
    end else if (expire) begin
      m_ti = 1'b1;
    end
    if (we && wa == 14'h041) begin
      m_tcfg = masked_merge(m_tcfg, '1);
      m_tval = {m_tcfg[31:2], 2'b00};
      m_en   = m_tcfg[0];
    end else if (expire) begin
      if (m_tcfg[1]) begin
        m_tval = {m_tcfg[31:2], 2'b00};
      end else begin
        m_en = 1'b0;
      end
    end else if (m_en) begin
      m_tval = m_tval - 32'd1;
    end
    m_cnt = m_cnt + 64'd1;
  endtask

  task automatic check_data(input string name, input csr_pkg::csr_word_t exp,
                            input csr_pkg::csr_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input csr_pkg::csr_status_t exp,
                              input csr_pkg::csr_status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %018h, actual %018h", name, exp, act);
    end
  endtask

  // mode 0 reset, 1 writes, 2 exceptions, 3 timer, 4 counter, 5 stall
  task automatic drive(input int mode, input int idx);
    csr_pkg::csr_wr_t       w;
    csr_pkg::excp_t         e;
    logic                   er;
    logic                   st;
    logic                   periodic;
    logic [1:0]             sel;
    logic [`HW_INT_W-1:0]   hw;
    logic [`CSR_ADDR_W-1:0] ra;
    csr_pkg::rdcnt_e        rc;
    w  = '0;
    e  = '0;
    er = 1'b0;
    st = 1'b0;
    hw = '0;
    ra = '0;
    rc = csr_pkg::CSR;
    case (mode)
      0: ra = kept_addr[idx % 13];
      1, 5: begin
        w.we   = rand_bit();
        w.addr = csr_pkg::csr_addr_e'(pick_addr());
        w.mask = rand_bits(32);
        w.data = rand_bits(32);
        ra     = rand_bit() ? w.addr : pick_addr();
        hw     = (rand_bits(2) == 0) ? 8'(rand_bits(8)) : 8'h00;
        st     = (mode == 5) ? rand_bit() : 1'b0;
      end
      2: begin
        e.valid    = rand_bit();
        e.ecode    = ecodes[rand_bits(3) % 6];
        e.esubcode = 9'(rand_bits(9));
        e.pc       = rand_bits(32);
        er         = rand_bit();
        sel        = 2'(rand_bits(2));
        w.we       = rand_bit();
        w.addr     = (sel == 0) ? csr_pkg::PRMD : (sel == 1) ? csr_pkg::ERA : csr_pkg::CRMD;
        w.mask     = rand_bits(32);
        w.data     = rand_bits(32);
        ra         = excp_rd[rand_bits(2)];
        hw         = (rand_bits(3) == 0) ? 8'(rand_bits(8)) : 8'h00;
      end
      3: begin
        if (idx % 64 == 0) begin
          periodic = rand_bit();
          w.we     = 1'b1;
          w.addr   = csr_pkg::TCFG;
          w.mask   = '1;
          w.data   = {27'd0, 3'(rand_bits(3)), periodic, 1'b1}; // small initval, enabled
        end else if (rand_bits(4) == 0) begin
          w.we   = 1'b1;
          w.addr = csr_pkg::TICLR;
          w.mask = rand_bits(32);
          w.data = rand_bits(32);
        end else if (rand_bits(5) == 0) begin
          w.we   = 1'b1;
          w.addr = csr_pkg::CRMD;
          w.mask = 32'h0000_0004;
          w.data = rand_bits(32);
        end
        ra = tmr_rd[rand_bits(2)];
      end
      default: begin
        rc = csr_pkg::rdcnt_e'(rand_bits(2));
        if (rand_bits(3) == 0) begin
          w.we   = 1'b1;
          w.addr = csr_pkg::TID;
          w.mask = rand_bits(32);
          w.data = rand_bits(32);
        end
        ra = pick_addr();
      end
    endcase
    csr_wr  <= w;
    excp    <= e;
    ertn    <= er;
    hw_int  <= hw;
    rd_addr <= ra;
    rdcnt   <= rc;
    stall   <= st;
  endtask

  task automatic run_test(input string name, input int mode, input int n);
    int err0;
    err0 = errors;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check_data({name, " rd_data_o"}, m_rd, rd_data);
      check_status({name, " csr_o"}, model_status(), csr_st);
      @(posedge clk);
      model_step();
      drive(mode, i);
    end
    if (errors == err0) begin
      tests_pass++;
      $display("test %-8s passed (%0d cycles)", name, n);
    end else begin
      tests_fail++;
      $display("test %-8s FAILED with %0d mismatches", name, errors - err0);
    end
  endtask

  initial begin
    rst_n   <= 1'b0;
    csr_wr  <= '0;
    excp    <= '0;
    ertn    <= 1'b0;
    hw_int  <= '0;
    rd_addr <= '0;
    rdcnt   <= csr_pkg::CSR;
    stall   <= 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    model_reset();
    run_test("reset", 0, N_RESET);
    run_test("writes", 1, N_WRITE);
    run_test("excp", 2, N_EXCP);
    run_test("timer", 3, N_TIMER);
    run_test("counter", 4, N_CNT);
    run_test("stall", 5, N_STALL);
    $display("tests passed %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
             tests_pass, tests_fail, checks, errors, dut_i.chk_i.fail_cnt);
    if (tests_fail == 0 && errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== csr_file.f ====
+incdir+source
source/csr_pkg.sv
source/csr_excp_regs.sv
source/csr_timer.sv
source/csr_save_bank.sv
source/csr_read_mux.sv
source/csr_file.sv
testbench/csr_file_chk.sv
testbench/csr_file_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build csr_file_tb with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f csr_file.f \
		--top-module csr_file_tb -Mdir obj_dir
	./obj_dir/Vcsr_file_tb +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
